//--- hw/isa_pkg.sv
package isa_pkg;

  localparam int inst_width = 32;
  localparam int reg_bits = 5;
  localparam int opcode_bits = 6;

  // field positions.
  localparam int opcode_lsb = 26;
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;

  //////////////////////////////////////////////////////////////////////

  typedef enum logic [opcode_bits-1:0] {
    op_nop   = 6'h00,  // also marks an empty slot.
    op_add   = 6'h01,
    op_sub   = 6'h02,
    op_cmp   = 6'h03,
    op_test  = 6'h04,
    op_jr    = 6'h0F,
    op_addi  = 6'h10,
    op_subi  = 6'h11,
    op_cmpi  = 6'h12,
    op_testi = 6'h13,
    op_lw    = 6'h20,
    op_sw    = 6'h21,
    op_la    = 6'h22,
    op_sa    = 6'h23,
    op_jmp   = 6'h30,
    op_je    = 6'h31,
    op_jo    = 6'h32
  } opcode_e;

  typedef enum logic [1:0] {
    mem_op_none  = 2'd0,
    mem_op_read  = 2'd1,
    mem_op_write = 2'd2
  } mem_op_e;

  //////////////////////////////////////////////////////////////////////

  function automatic opcode_e get_opcode(input logic [inst_width-1:0] inst);
    return opcode_e'(inst[opcode_lsb +: opcode_bits]);
  endfunction

  function automatic logic [reg_bits-1:0] get_rs(input logic [inst_width-1:0] inst);
    return inst[rs_lsb +: reg_bits];
  endfunction

  function automatic logic [reg_bits-1:0] get_rt(input logic [inst_width-1:0] inst);
    return inst[rt_lsb +: reg_bits];
  endfunction

  function automatic logic [reg_bits-1:0] get_rd(input logic [inst_width-1:0] inst);
    return inst[rd_lsb +: reg_bits];
  endfunction

endpackage

//--- hw/issue_pkg.sv
package issue_pkg;

  // execution pipe an instruction needs.
  typedef enum logic [1:0] {
    pipe_dont_care = 2'd0,
    pipe_memory    = 2'd1,
    pipe_branch    = 2'd2
  } pipe_class_e;

  // one bit per register field.
  typedef logic [2:0] reg_use_t;

  localparam reg_use_t use_none = 3'b000;
  localparam reg_use_t use_rs   = 3'b001;
  localparam reg_use_t use_rt   = 3'b010;
  localparam reg_use_t use_rd   = 3'b100;

  // bit n set means slot n may still issue.
  typedef logic [1:0] slot_mask_t;

endpackage

//--- hw/load_hazard.sv
`timescale 1ns/1ns

module load_hazard
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic [inst_width-1:0] ahead_instruction,
  input  mem_op_e               ahead_mem_op,
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  output slot_mask_t            slot_mask,
  output logic                  load_stall
);

  logic [reg_bits-1:0] ahead_rt;
  logic                hit0;
  logic                hit1;

  assign ahead_rt = get_rt(ahead_instruction);  // load target.

  assign hit0 = (get_rs(instruction0) == ahead_rt) ||
                (get_rt(instruction0) == ahead_rt);
  assign hit1 = (get_rs(instruction1) == ahead_rt) ||
                (get_rt(instruction1) == ahead_rt);

  // the whole pair waits for the load data.
  assign load_stall = (ahead_mem_op == mem_op_read) && (hit0 || hit1);
  assign slot_mask  = load_stall ? 2'b00 : 2'b11;

endmodule

//--- hw/split_hazard.sv
`timescale 1ns/1ns

module split_hazard
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  input  slot_mask_t            slot_mask_in,
  output slot_mask_t            slot_mask_out,
  output logic                  split_stall
);

  logic [inst_width-1:0] inst0;
  logic [inst_width-1:0] inst1;
  reg_use_t              dst0;
  reg_use_t              src1;
  logic [reg_bits-1:0]   dst_reg0;
  logic                  rs_hit;
  logic                  rt_hit;

  function automatic reg_use_t src_use(input opcode_e op);
    reg_use_t src;
    case (op) inside
      op_nop, 6'b11????: begin  // branches touch no gpr.
        src = use_none;
      end
      op_jr, 6'b01????, op_lw: begin
        src = use_rs;
      end
      6'b00????, op_sw: begin  // register alu and store.
        src = use_rs | use_rt;
      end
      op_sa: begin
        src = use_rt;
      end
      default: begin
        src = use_none;
      end
    endcase
    return src;
  endfunction

  function automatic reg_use_t dst_use(input opcode_e op);
    reg_use_t dst;
    case (op) inside
      op_nop, op_jr: begin
        dst = use_none;
      end
      6'b00????: begin  // register alu.
        dst = use_rd;
      end
      6'b01????, op_lw, op_la: begin  // immediate alu and loads.
        dst = use_rt;
      end
      default: begin
        dst = use_none;
      end
    endcase
    return dst;
  endfunction

  // masked slots look like nops.
  assign inst0 = slot_mask_in[0] ? instruction0 : '0;
  assign inst1 = slot_mask_in[1] ? instruction1 : '0;

  assign dst0 = dst_use(get_opcode(inst0));
  assign src1 = src_use(get_opcode(inst1));

  assign dst_reg0 = ((dst0 & use_rt) != use_none) ? get_rt(inst0) : get_rd(inst0);

  assign rs_hit = ((src1 & use_rs) != use_none) && (get_rs(inst1) == dst_reg0);
  assign rt_hit = ((src1 & use_rt) != use_none) && (get_rt(inst1) == dst_reg0);

  assign split_stall   = (dst0 != use_none) && (rs_hit || rt_hit);
  assign slot_mask_out = slot_mask_in & {~split_stall, 1'b1};

endmodule

//--- hw/steer.sv
`timescale 1ns/1ns

module steer
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic [inst_width-1:0] instruction0,
  input  logic [inst_width-1:0] instruction1,
  input  slot_mask_t            slot_mask_in,
  output slot_mask_t            slot_mask_out,
  output logic                  steer_stall,
  output logic                  first
);

  logic [inst_width-1:0] inst0;
  logic [inst_width-1:0] inst1;
  pipe_class_e           pipe0;
  pipe_class_e           pipe1;

  function automatic pipe_class_e pipe_of(input opcode_e op);
    pipe_class_e pipe;
    case (op) inside
      op_cmp, op_test, op_cmpi, op_testi: pipe = pipe_branch;  // set flags.
      6'b10????: pipe = pipe_memory;
      6'b11????: pipe = pipe_branch;
      default: pipe = pipe_dont_care;
    endcase
    return pipe;
  endfunction

  assign inst0 = slot_mask_in[0] ? instruction0 : '0;
  assign inst1 = slot_mask_in[1] ? instruction1 : '0;

  assign pipe0 = pipe_of(get_opcode(inst0));
  assign pipe1 = pipe_of(get_opcode(inst1));

  ////////////////////////////////////////////////////////////////////
  // memory pipe sits behind slot 1, branch pipe behind slot 0
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    steer_stall   = 1'b0;
    first         = 1'b0;
    slot_mask_out = slot_mask_in;
    case ({pipe0, pipe1})
      {pipe_branch, pipe_branch}: begin
        steer_stall   = 1'b1;
        slot_mask_out = slot_mask_in & 2'b01;
      end
      {pipe_memory, pipe_memory}: begin
        steer_stall   = 1'b1;
        first         = 1'b1;  // lone load goes to slot 1.
        slot_mask_out = slot_mask_in & 2'b01;
      end
      {pipe_memory, pipe_branch},
      {pipe_memory, pipe_dont_care},
      {pipe_dont_care, pipe_branch}: begin
        first = 1'b1;
      end
      default: begin
        first = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/issue.sv
`timescale 1ns/1ns

module issue
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter int addr_width = 32,
  parameter int id_width   = 6
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  flush,
  input  logic [inst_width-1:0] ahead_instruction,
  input  mem_op_e               ahead_mem_op,
  input  logic [inst_width-1:0] instruction0_in,
  input  logic [inst_width-1:0] instruction1_in,
  input  logic [addr_width-1:0] pc0_in,
  input  logic [addr_width-1:0] pc1_in,
  input  logic [id_width-1:0]   id0_in,
  input  logic [id_width-1:0]   id1_in,
  output logic [inst_width-1:0] instruction0_out,
  output logic [inst_width-1:0] instruction1_out,
  output logic [addr_width-1:0] pc0_out,
  output logic [addr_width-1:0] pc1_out,
  output logic [id_width-1:0]   id0_out,
  output logic [id_width-1:0]   id1_out,
  output logic                  first,
  output logic                  stall_out
);

  logic [inst_width-1:0] held_instruction0;
  logic [inst_width-1:0] held_instruction1;
  logic [addr_width-1:0] held_pc0;
  logic [addr_width-1:0] held_pc1;
  logic [id_width-1:0]   held_id0;
  logic [id_width-1:0]   held_id1;
  logic                  held_valid;

  logic [inst_width-1:0] work_instruction0;
  logic [inst_width-1:0] work_instruction1;
  logic [addr_width-1:0] work_pc0;
  logic [addr_width-1:0] work_pc1;
  logic [id_width-1:0]   work_id0;
  logic [id_width-1:0]   work_id1;

  slot_mask_t            load_mask;
  slot_mask_t            split_mask;
  slot_mask_t            final_mask;

  ////////////////////////////////////////////////////////////////////
  // working pair
  ////////////////////////////////////////////////////////////////////

  assign held_valid = (held_instruction0 != '0) || (held_instruction1 != '0);

  assign work_instruction0 = held_valid ? held_instruction0 : instruction0_in;
  assign work_instruction1 = held_valid ? held_instruction1 : instruction1_in;
  assign work_pc0          = held_valid ? held_pc0 : pc0_in;
  assign work_pc1          = held_valid ? held_pc1 : pc1_in;
  assign work_id0          = held_valid ? held_id0 : id0_in;
  assign work_id1          = held_valid ? held_id1 : id1_in;

  load_hazard u_load_hazard (
    .ahead_instruction (ahead_instruction),
    .ahead_mem_op      (ahead_mem_op),
    .instruction0      (work_instruction0),
    .instruction1      (work_instruction1),
    .slot_mask         (load_mask),
    .load_stall        ()
  );

  split_hazard u_split_hazard (
    .instruction0  (work_instruction0),
    .instruction1  (work_instruction1),
    .slot_mask_in  (load_mask),
    .slot_mask_out (split_mask),
    .split_stall   ()
  );

  steer u_steer (
    .instruction0  (work_instruction0),
    .instruction1  (work_instruction1),
    .slot_mask_in  (split_mask),
    .slot_mask_out (final_mask),
    .steer_stall   (),
    .first         (first)
  );

  assign stall_out = !(final_mask[0] && final_mask[1]);

  ////////////////////////////////////////////////////////////////////
  // output slots
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    instruction0_out = '0;
    instruction1_out = '0;
    pc0_out          = '0;
    pc1_out          = '0;
    id0_out          = '0;
    id1_out          = '0;
    if (!flush) begin
      if (final_mask[0] && !first) begin
        instruction0_out = work_instruction0;
        pc0_out          = work_pc0;
        id0_out          = work_id0;
      end
      if (final_mask[0] && first) begin  // swapped into slot 1.
        instruction1_out = work_instruction0;
        pc1_out          = work_pc0;
        id1_out          = work_id0;
      end
      if (final_mask[1] && !first) begin
        instruction1_out = work_instruction1;
        pc1_out          = work_pc1;
        id1_out          = work_id1;
      end
      if (final_mask[1] && first) begin
        instruction0_out = work_instruction1;
        pc0_out          = work_pc1;
        id0_out          = work_id1;
      end
    end
  end

  // unissued slots wait here, issued ones leave a hole.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held_instruction0 <= '0;
      held_instruction1 <= '0;
      held_pc0          <= '0;
      held_pc1          <= '0;
      held_id0          <= '0;
      held_id1          <= '0;
    end else if (flush) begin
      held_instruction0 <= '0;
      held_instruction1 <= '0;
      held_pc0          <= '0;
      held_pc1          <= '0;
      held_id0          <= '0;
      held_id1          <= '0;
    end else begin
      held_instruction0 <= final_mask[0] ? '0 : work_instruction0;
      held_instruction1 <= final_mask[1] ? '0 : work_instruction1;
      held_pc0          <= final_mask[0] ? '0 : work_pc0;
      held_pc1          <= final_mask[1] ? '0 : work_pc1;
      held_id0          <= final_mask[0] ? '0 : work_id0;
      held_id1          <= final_mask[1] ? '0 : work_id1;
    end
  end

endmodule

//--- bench/issue_tb.sv
`timescale 1ns/1ns

module issue_tb
  import isa_pkg::*;
  import issue_pkg::*;
();

  localparam int addr_width = 32;
  localparam int id_width   = 6;
  localparam int max_cycles = 600;  // 8 reset, ~40 directed, 300 random, with margin.

  logic                  clk;
  logic                  arst_n;
  logic                  flush;
  logic [inst_width-1:0] ahead_instruction;
  mem_op_e               ahead_mem_op;
  logic [inst_width-1:0] instruction0_in;
  logic [inst_width-1:0] instruction1_in;
  logic [addr_width-1:0] pc0_in;
  logic [addr_width-1:0] pc1_in;
  logic [id_width-1:0]   id0_in;
  logic [id_width-1:0]   id1_in;
  logic [inst_width-1:0] instruction0_out;
  logic [inst_width-1:0] instruction1_out;
  logic [addr_width-1:0] pc0_out;
  logic [addr_width-1:0] pc1_out;
  logic [id_width-1:0]   id0_out;
  logic [id_width-1:0]   id1_out;
  logic                  first;
  logic                  stall_out;

  integer      seed        = 75476;
  int          cycle_count = 0;
  logic [31:0] model_inst [2] = '{32'h0, 32'h0};  // pending pair of the model.
  logic [31:0] model_pc [2]   = '{32'h0, 32'h0};
  logic [5:0]  model_id [2]   = '{6'h0, 6'h0};
  opcode_e     op_list [17]   = '{op_nop, op_add, op_sub, op_cmp, op_test, op_jr, op_addi,
                                  op_subi, op_cmpi, op_testi, op_lw, op_sw, op_la, op_sa,
                                  op_jmp, op_je, op_jo};

  issue #(
    .addr_width (addr_width),
    .id_width   (id_width)
  ) u_issue (
    .clk               (clk),
    .arst_n            (arst_n),
    .flush             (flush),
    .ahead_instruction (ahead_instruction),
    .ahead_mem_op      (ahead_mem_op),
    .instruction0_in   (instruction0_in),
    .instruction1_in   (instruction1_in),
    .pc0_in            (pc0_in),
    .pc1_in            (pc1_in),
    .id0_in            (id0_in),
    .id1_in            (id1_in),
    .instruction0_out  (instruction0_out),
    .instruction1_out  (instruction1_out),
    .pc0_out           (pc0_out),
    .pc1_out           (pc1_out),
    .id0_out           (id0_out),
    .id1_out           (id1_out),
    .first             (first),
    .stall_out         (stall_out)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] encode(input opcode_e op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic pipe_class_e pipe_for(input logic [31:0] w);
    logic [5:0] op;
    op = w[31:26];
    if (op[5:4] == 2'b11 || op == op_cmp || op == op_test || op == op_cmpi || op == op_testi)
      return pipe_branch;
    if (op[5:4] == 2'b10)
      return pipe_memory;
    return pipe_dont_care;
  endfunction

  // true when w1 reads the register that w0 writes.
  function automatic logic depends(input logic [31:0] w0, input logic [31:0] w1);
    logic [5:0] op0;
    logic [5:0] op1;
    logic [4:0] dst;
    logic       has_dst;
    logic       reads_rs;
    logic       reads_rt;
    op0     = w0[31:26];
    op1     = w1[31:26];
    dst     = '0;
    has_dst = 1'b1;
    if (op0[5:4] == 2'b00 && op0 != op_nop && op0 != op_jr)
      dst = w0[15:11];
    else if (op0[5:4] == 2'b01 || op0 == op_lw || op0 == op_la)
      dst = w0[20:16];
    else
      has_dst = 1'b0;
    reads_rs = (op1[5:4] == 2'b00 && op1 != op_nop) || op1[5:4] == 2'b01 ||
               op1 == op_lw || op1 == op_sw;
    reads_rt = (op1[5:4] == 2'b00 && op1 != op_nop && op1 != op_jr) ||
               op1 == op_sw || op1 == op_sa;
    return has_dst && ((reads_rs && w1[25:21] == dst) || (reads_rt && w1[20:16] == dst));
  endfunction

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val)
    else begin
      $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
      stop_on_error();
    end
  endtask

  task automatic set_pair(input logic [31:0] i0, input logic [31:0] i1, input logic [31:0] a0,
                          input logic [31:0] a1, input logic [5:0] t0, input logic [5:0] t1);
    instruction0_in <= i0;
    instruction1_in <= i1;
    pc0_in          <= a0;
    pc1_in          <= a1;
    id0_in          <= t0;
    id1_in          <= t1;
  endtask

  // hold the pair until a cycle with stall_out low.
  task automatic wait_issue();
    @(negedge clk);
    while (stall_out) @(negedge clk);
  endtask

  task automatic present_pair(input logic [31:0] i0, input logic [31:0] i1,
                              input logic [31:0] a0, input logic [31:0] a1,
                              input logic [5:0] t0, input logic [5:0] t1);
    @(posedge clk);
    set_pair(i0, i1, a0, a1, t0, t1);
    wait_issue();
  endtask

  task automatic draw_inst(output logic [31:0] w);
    logic [31:0] r;
    int          idx;
    opcode_e     op;
    r   = $random(seed);
    idx = int'(r % 17);
    op  = op_list[idx];
    w   = (op == op_nop) ? '0 : encode(op, {2'b00, r[7:5]}, {2'b00, r[10:8]}, {2'b00, r[13:11]});
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      stop_on_error();
    end
  end

  always @(negedge clk) begin : reference_model
    logic [31:0] w [2];
    logic [31:0] a [2];
    logic [5:0]  t [2];
    logic [31:0] e_inst [2];
    logic [31:0] e_pc [2];
    logic [5:0]  e_id [2];
    logic [4:0]  art;
    logic [1:0]  m;
    logic        use_held;
    logic        swap;
    pipe_class_e p0;
    pipe_class_e p1;
    int          slot;
    use_held = (model_inst[0] != '0) || (model_inst[1] != '0);
    w[0] = use_held ? model_inst[0] : instruction0_in;
    w[1] = use_held ? model_inst[1] : instruction1_in;
    a[0] = use_held ? model_pc[0] : pc0_in;
    a[1] = use_held ? model_pc[1] : pc1_in;
    t[0] = use_held ? model_id[0] : id0_in;
    t[1] = use_held ? model_id[1] : id1_in;
    art  = ahead_instruction[20:16];
    m    = 2'b11;
    if (ahead_mem_op == mem_op_read && (w[0][25:21] == art || w[0][20:16] == art ||
                                        w[1][25:21] == art || w[1][20:16] == art))
      m = 2'b00;
    if (depends(m[0] ? w[0] : '0, m[1] ? w[1] : '0))
      m[1] = 1'b0;
    p0   = pipe_for(m[0] ? w[0] : '0);
    p1   = pipe_for(m[1] ? w[1] : '0);
    swap = 1'b0;
    if (p0 == pipe_branch && p1 == pipe_branch) begin
      m[1] = 1'b0;
    end else if (p0 == pipe_memory && p1 == pipe_memory) begin
      m[1] = 1'b0;
      swap = 1'b1;
    end else if (p0 == pipe_memory || (p0 == pipe_dont_care && p1 == pipe_branch)) begin
      swap = 1'b1;
    end
    for (int n = 0; n < 2; n++) begin
      e_inst[n] = '0;
      e_pc[n]   = '0;
      e_id[n]   = '0;
    end
    for (int n = 0; n < 2; n++) begin
      slot = swap ? 1 - n : n;
      if (m[n] && !flush) begin
        e_inst[slot] = w[n];
        e_pc[slot]   = a[n];
        e_id[slot]   = t[n];
      end
    end
    check_value("instruction0_out", e_inst[0], instruction0_out);
    check_value("instruction1_out", e_inst[1], instruction1_out);
    check_value("pc0_out", e_pc[0], pc0_out);
    check_value("pc1_out", e_pc[1], pc1_out);
    check_value("id0_out", 32'(e_id[0]), 32'(id0_out));
    check_value("id1_out", 32'(e_id[1]), 32'(id1_out));
    check_value("first", 32'(swap), 32'(first));
    check_value("stall_out", 32'(!(m[0] && m[1])), 32'(stall_out));
    for (int n = 0; n < 2; n++) begin
      model_inst[n] = (!arst_n || flush || m[n]) ? '0 : w[n];  // state after the next edge.
      model_pc[n]   = (!arst_n || flush || m[n]) ? '0 : a[n];
      model_id[n]   = (!arst_n || flush || m[n]) ? '0 : t[n];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] i0;
    logic [31:0] i1;
    logic [31:0] r;
    logic        stall_seen;
    arst_n            = 1'b0;
    flush             = 1'b0;
    ahead_instruction = '0;
    ahead_mem_op      = mem_op_none;
    instruction0_in   = '0;
    instruction1_in   = '0;
    pc0_in            = '0;
    pc1_in            = '0;
    id0_in            = '0;
    id1_in            = '0;
    stall_seen        = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);  // idle with zero inputs.
    present_pair(encode(op_add, 5'd1, 5'd2, 5'd3), encode(op_sub, 5'd4, 5'd6, 5'd8),
                 32'h100, 32'h104, 6'd1, 6'd2);
    present_pair(encode(op_add, 5'd1, 5'd2, 5'd5), encode(op_addi, 5'd5, 5'd9, 5'd0),
                 32'h108, 32'h10c, 6'd3, 6'd4);
    // load to r7 one stage ahead.
    @(posedge clk);
    ahead_instruction <= encode(op_lw, 5'd1, 5'd7, 5'd0);
    ahead_mem_op      <= mem_op_read;
    set_pair(encode(op_add, 5'd7, 5'd2, 5'd10), encode(op_sub, 5'd3, 5'd4, 5'd11),
             32'h110, 32'h114, 6'd5, 6'd6);
    repeat (4) @(posedge clk);
    ahead_mem_op <= mem_op_none;
    wait_issue();
    present_pair(encode(op_lw, 5'd1, 5'd3, 5'd0), encode(op_je, 5'd0, 5'd0, 5'd0),
                 32'h118, 32'h11c, 6'd7, 6'd8);
    present_pair(encode(op_jmp, 5'd0, 5'd0, 5'd0), encode(op_je, 5'd0, 5'd0, 5'd0),
                 32'h120, 32'h124, 6'd9, 6'd10);
    present_pair(encode(op_lw, 5'd1, 5'd3, 5'd0), encode(op_sw, 5'd2, 5'd4, 5'd0),
                 32'h128, 32'h12c, 6'd11, 6'd12);
    // fill the buffer, then flush it.
    @(posedge clk);
    set_pair(encode(op_add, 5'd1, 5'd2, 5'd5), encode(op_addi, 5'd5, 5'd9, 5'd0),
             32'h130, 32'h134, 6'd13, 6'd14);
    @(posedge clk);
    flush <= 1'b1;
    set_pair(encode(op_sub, 5'd2, 5'd3, 5'd12), encode(op_add, 5'd4, 5'd6, 5'd13),
             32'h200, 32'h204, 6'd15, 6'd16);
    @(posedge clk);
    flush <= 1'b0;
    wait_issue();
    repeat (300) begin
      @(posedge clk);
      if (!stall_seen) begin
        draw_inst(i0);
        draw_inst(i1);
        r = $random(seed);
        set_pair(i0, i1, r, ~r, r[5:0], r[11:6]);
      end
      r = $random(seed);
      ahead_instruction <= encode(op_lw, r[4:0], {2'b00, r[7:5]}, 5'd0);
      ahead_mem_op      <= (r[9:8] == 2'd3) ? mem_op_none : mem_op_e'(r[9:8]);
      flush             <= (r[15:12] == 4'h0);
      @(negedge clk);
      stall_seen = stall_out;
    end
    @(posedge clk);
    set_pair('0, '0, '0, '0, '0, '0);
    ahead_mem_op <= mem_op_none;
    flush        <= 1'b0;
    repeat (4) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- files.f
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/load_hazard.sv
hw/split_hazard.sv
hw/steer.sv
hw/issue.sv
bench/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -f files.f --top-module issue_tb -o issue_tb \
  > sim.log 2>&1 && ./obj_dir/issue_tb >> sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log
if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
